/* source/npc_pkg.sv */
/*
 * Next-PC predictor package
 * Widths, table sizes, config register map and shared vector types
 */
`default_nettype none

package npc_pkg;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] pc_t;

    //////////////////////////////////////////////////
    // Bimodal direction table
    //////////////////////////////////////////////////
    // Indexed by fetch PC bits 7:2
    localparam int DIRP_IDX_LEN = 6;
    localparam int DIRP_ENTRIES = 1 << DIRP_IDX_LEN;
    typedef logic [DIRP_IDX_LEN-1:0] dirp_idx_t;

    // Two-bit saturating counter
    localparam int CNT_LEN = 2;
    typedef logic [CNT_LEN-1:0] counter_t;
    localparam counter_t CNT_MIN     = 2'd0;
    localparam counter_t CNT_WEAK_NT = 2'd1;
    localparam counter_t CNT_MAX     = 2'd3;

    // Branch target buffer, indexed by PC bits 5:2
    localparam int BTB_IDX_LEN = 4;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_LEN;
    typedef logic [BTB_IDX_LEN-1:0] btb_idx_t;

    // Return address stack
    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_LEN = 3;
    typedef logic [RAS_PTR_LEN-1:0] ras_ptr_t;
    // One extra bit so a full stack can be told from an empty one
    typedef logic [RAS_PTR_LEN:0] ras_cnt_t;
    localparam ras_cnt_t RAS_FULL = ras_cnt_t'(RAS_DEPTH);

    //////////////////////////////////////////////////
    // Wishbone config registers
    //////////////////////////////////////////////////
    localparam int WB_ADR_LEN = 4;
    localparam int WB_DAT_LEN = 32;
    typedef logic [WB_ADR_LEN-1:0] wb_adr_t;
    typedef logic [WB_DAT_LEN-1:0] wb_dat_t;

    localparam wb_adr_t REG_CTRL_ADR  = 4'h0;
    localparam wb_adr_t REG_REDIR_ADR = 4'h4;

    // Control register enable bits
    localparam int CTRL_LEN      = 3;
    typedef logic [CTRL_LEN-1:0] ctrl_t;
    localparam int CTRL_DIRP_BIT = 0;
    localparam int CTRL_BTB_BIT  = 1;
    localparam int CTRL_RAS_BIT  = 2;
    // All predictors on out of reset
    localparam ctrl_t CTRL_RESET = 3'h7;

endpackage

`default_nettype wire

/* source/dirp_bimodal.sv */
/*
 * Bimodal direction predictor
 * 64 two-bit saturating counters indexed by fetch PC bits 7:2,
 * trained by two resolved-branch ports
 */
`timescale 1ns/1ps
`default_nettype none

module dirp_bimodal (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                is_branch,
    input  npc_pkg::pc_t        pc_in,
    input  logic                train_valid_0,
    input  logic                train_taken_0,
    input  npc_pkg::dirp_idx_t  train_idx_0,
    input  logic                train_valid_1,
    input  logic                train_taken_1,
    input  npc_pkg::dirp_idx_t  train_idx_1,
    output logic                taken,
    output npc_pkg::dirp_idx_t  dirp_tag
);

    // Saturating step, up on taken and down on not taken
    function automatic npc_pkg::counter_t cnt_step(
        input npc_pkg::counter_t cur,
        input logic              up
    );
        npc_pkg::counter_t nxt;
        nxt = cur;
        if (up && cur != npc_pkg::CNT_MAX) begin
            nxt = cur + 1'b1;
        end else if (!up && cur != npc_pkg::CNT_MIN) begin
            nxt = cur - 1'b1;
        end
        return nxt;
    endfunction

    npc_pkg::counter_t  cnt_q [npc_pkg::DIRP_ENTRIES];
    npc_pkg::dirp_idx_t rd_idx;
    npc_pkg::counter_t  port1_base;
    logic               same_idx;

    //////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////
    assign rd_idx   = pc_in[npc_pkg::DIRP_IDX_LEN+1:2];
    // Tag comes back later from execute as ex_idx
    assign dirp_tag = rd_idx;
    // Upper half of the counter range means taken
    assign taken    = is_branch && cnt_q[rd_idx][npc_pkg::CNT_LEN-1];

    //////////////////////////////////////////////////
    // Training
    //////////////////////////////////////////////////
    // Both ports on one counter
    assign same_idx   = train_valid_0 && train_valid_1 && (train_idx_0 == train_idx_1);
    // Port 1 steps from the port 0 result on a collision
    assign port1_base = same_idx ? cnt_step(cnt_q[train_idx_0], train_taken_0)
                                 : cnt_q[train_idx_1];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < npc_pkg::DIRP_ENTRIES; i++) begin
                cnt_q[i] <= npc_pkg::CNT_WEAK_NT;
            end
        end else begin
            if (train_valid_0 && !same_idx) begin
                cnt_q[train_idx_0] <= cnt_step(cnt_q[train_idx_0], train_taken_0);
            end
            if (train_valid_1) begin
                cnt_q[train_idx_1] <= cnt_step(port1_base, train_taken_1);
            end
        end
    end

    // No taken prediction for non-branch fetches
    a_taken_needs_branch: assert property (
        @(posedge clock) disable iff (!rst_n) taken |-> is_branch
    );

endmodule

`default_nettype wire

/* source/btb.sv */
/*
 * Branch target buffer
 * Direct-mapped, 16 entries of valid bit, full branch PC and target,
 * one read port and two write ports with port 1 winning
 */
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          read_en,
    input  npc_pkg::pc_t  pc_r,
    input  logic          write_en_0,
    input  npc_pkg::pc_t  pc_w_0,
    input  npc_pkg::pc_t  target_0,
    input  logic          write_en_1,
    input  npc_pkg::pc_t  pc_w_1,
    input  npc_pkg::pc_t  target_1,
    output npc_pkg::pc_t  target_out,
    output logic          hit
);

    logic [npc_pkg::BTB_ENTRIES-1:0] valid_q;
    npc_pkg::pc_t                    pc_q  [npc_pkg::BTB_ENTRIES];
    npc_pkg::pc_t                    tgt_q [npc_pkg::BTB_ENTRIES];

    npc_pkg::btb_idx_t rd_idx;
    npc_pkg::btb_idx_t wr_idx_0;
    npc_pkg::btb_idx_t wr_idx_1;

    // Word-aligned PC bits 5:2
    assign rd_idx   = pc_r[npc_pkg::BTB_IDX_LEN+1:2];
    assign wr_idx_0 = pc_w_0[npc_pkg::BTB_IDX_LEN+1:2];
    assign wr_idx_1 = pc_w_1[npc_pkg::BTB_IDX_LEN+1:2];

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////
    // Full PC compare stands in for a tag
    assign hit        = read_en && valid_q[rd_idx] && (pc_q[rd_idx] == pc_r);
    assign target_out = tgt_q[rd_idx];

    //////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////
    // Valid bits
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (write_en_0) begin
                valid_q[wr_idx_0] <= 1'b1;
            end
            if (write_en_1) begin
                valid_q[wr_idx_1] <= 1'b1;
            end
        end
    end

    // Entry contents
    // Port 1 is assigned last and wins on a shared index
    always_ff @(posedge clock) begin
        if (write_en_0) begin
            pc_q[wr_idx_0]  <= pc_w_0;
            tgt_q[wr_idx_0] <= target_0;
        end
        if (write_en_1) begin
            pc_q[wr_idx_1]  <= pc_w_1;
            tgt_q[wr_idx_1] <= target_1;
        end
    end

    // A hit always points at a written entry
    a_hit_target_known: assert property (
        @(posedge clock) disable iff (!rst_n) hit |-> !$isunknown(target_out)
    );

endmodule

`default_nettype wire

/* source/ras.sv */
/*
 * Return address stack
 * Circular 8-entry stack, push on call, pop on return,
 * oldest entry lost on overflow, emptied by squash
 */
`timescale 1ns/1ps
`default_nettype none

module ras (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          squash,
    input  logic          push,
    input  logic          pop,
    input  npc_pkg::pc_t  push_addr,
    output npc_pkg::pc_t  top,
    output logic          ras_valid
);

    npc_pkg::pc_t     stack_q [npc_pkg::RAS_DEPTH];
    npc_pkg::ras_ptr_t wr_ptr_q;
    npc_pkg::ras_ptr_t top_ptr;
    npc_pkg::ras_cnt_t count_q;
    logic              has_entry;
    logic              do_push;
    logic              do_pop;
    logic              replace;

    // Pointer wraps over 8 slots
    assign top_ptr   = wr_ptr_q - 1'b1;
    assign has_entry = (count_q != '0);
    assign do_push   = push && !squash;
    assign do_pop    = pop && !squash && has_entry;
    // Call and return together swap the top entry
    assign replace   = do_push && do_pop;

    assign top       = stack_q[top_ptr];
    assign ras_valid = has_entry;

    //////////////////////////////////////////////////
    // Pointer and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (squash) begin
            count_q <= '0;
        end else if (do_push && !replace) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            // Full stack overwrites the oldest and keeps its count
            if (count_q != npc_pkg::RAS_FULL) begin
                count_q <= count_q + 1'b1;
            end
        end else if (do_pop && !replace) begin
            wr_ptr_q <= top_ptr;
            count_q  <= count_q - 1'b1;
        end
    end

    // Stack storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            stack_q[replace ? top_ptr : wr_ptr_q] <= push_addr;
        end
    end

    // Occupancy never past the depth
    a_count_bound: assert property (
        @(posedge clock) disable iff (!rst_n) count_q <= npc_pkg::RAS_FULL
    );

endmodule

`default_nettype wire

/* source/npc_control.sv */
/*
 * Next-PC selection
 * Combines direction table, BTB and return stack under the
 * enable bits, qualifies resolve ports and flags redirects
 */
`timescale 1ns/1ps
`default_nettype none

module npc_control (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                squash,
    input  logic                is_branch,
    input  logic                is_jump,
    input  logic                is_return,
    input  npc_pkg::pc_t        pc_in,
    input  npc_pkg::pc_t        pc_plus_4,
    // Resolve port 0
    input  logic                ex_valid_0,
    input  logic                ex_is_branch_0,
    input  logic                ex_taken_0,
    input  npc_pkg::pc_t        ex_pc_0,
    input  npc_pkg::pc_t        ex_target_0,
    input  npc_pkg::dirp_idx_t  ex_idx_0,
    // Resolve port 1
    input  logic                ex_valid_1,
    input  logic                ex_is_branch_1,
    input  logic                ex_taken_1,
    input  npc_pkg::pc_t        ex_pc_1,
    input  npc_pkg::pc_t        ex_target_1,
    input  npc_pkg::dirp_idx_t  ex_idx_1,
    // Enables from the config block
    input  logic                dirp_en,
    input  logic                btb_en,
    input  logic                ras_en,
    output npc_pkg::pc_t        npc_out,
    output logic                branch_predict,
    output npc_pkg::dirp_idx_t  dirp_tag,
    output logic                redirect
);

    logic         dir_taken;
    logic         btb_hit;
    npc_pkg::pc_t btb_target;
    npc_pkg::pc_t ras_top;
    logic         ras_valid;
    logic         use_ras;
    logic         train_0;
    logic         train_1;

    // Only resolved branches train
    assign train_0 = ex_valid_0 && ex_is_branch_0;
    assign train_1 = ex_valid_1 && ex_is_branch_1;

    //////////////////////////////////////////////////
    // Next PC mux
    //////////////////////////////////////////////////
    assign branch_predict = dir_taken && btb_hit && dirp_en && btb_en;
    assign use_ras        = is_return && ras_valid && ras_en;

    // Return first, then predicted branch, then fall through
    assign npc_out  = use_ras        ? ras_top    :
                      branch_predict ? btb_target : pc_plus_4;
    assign redirect = use_ras || branch_predict;

    dirp_bimodal u_dirp_bimodal (
        .clock         (clock),
        .rst_n         (rst_n),
        .is_branch     (is_branch),
        .pc_in         (pc_in),
        .train_valid_0 (train_0),
        .train_taken_0 (ex_taken_0),
        .train_idx_0   (ex_idx_0),
        .train_valid_1 (train_1),
        .train_taken_1 (ex_taken_1),
        .train_idx_1   (ex_idx_1),
        .taken         (dir_taken),
        .dirp_tag      (dirp_tag)
    );

    // Written by every resolved branch, taken or not
    btb u_btb (
        .clock      (clock),
        .rst_n      (rst_n),
        .read_en    (is_branch),
        .pc_r       (pc_in),
        .write_en_0 (train_0),
        .pc_w_0     (ex_pc_0),
        .target_0   (ex_target_0),
        .write_en_1 (train_1),
        .pc_w_1     (ex_pc_1),
        .target_1   (ex_target_1),
        .target_out (btb_target),
        .hit        (btb_hit)
    );

    // Stack frozen while disabled
    ras u_ras (
        .clock     (clock),
        .rst_n     (rst_n),
        .squash    (squash),
        .push      (is_jump && ras_en),
        .pop       (is_return && ras_en),
        .push_addr (pc_plus_4),
        .top       (ras_top),
        .ras_valid (ras_valid)
    );

endmodule

`default_nettype wire

/* source/predictor_config.sv */
/*
 * Predictor configuration block
 * Wishbone classic slave with the enable register and a
 * saturating count of fetch redirect cycles
 */
`timescale 1ns/1ps
`default_nettype none

module predictor_config (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  npc_pkg::wb_adr_t  wb_adr,
    input  npc_pkg::wb_dat_t  wb_dat_w,
    output npc_pkg::wb_dat_t  wb_dat_r,
    output logic              wb_ack,
    input  logic              redirect,
    output logic              dirp_en,
    output logic              btb_en,
    output logic              ras_en
);

    npc_pkg::ctrl_t   ctrl_q;
    npc_pkg::wb_dat_t redir_cnt_q;
    logic             wb_req;
    logic             redir_clr;

    //////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////
    // New request only while ack is low
    assign wb_req    = wb_cyc && wb_stb && !wb_ack;
    assign redir_clr = wb_req && wb_we && (wb_adr == npc_pkg::REG_REDIR_ADR);

    // Ack one cycle after the request
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Enable register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= npc_pkg::CTRL_RESET;
        end else if (wb_req && wb_we && (wb_adr == npc_pkg::REG_CTRL_ADR)) begin
            ctrl_q <= wb_dat_w[npc_pkg::CTRL_LEN-1:0];
        end
    end

    assign dirp_en = ctrl_q[npc_pkg::CTRL_DIRP_BIT];
    assign btb_en  = ctrl_q[npc_pkg::CTRL_BTB_BIT];
    assign ras_en  = ctrl_q[npc_pkg::CTRL_RAS_BIT];

    // Redirect counter where a clear beats a count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            redir_cnt_q <= '0;
        end else if (redir_clr) begin
            redir_cnt_q <= '0;
        end else if (redirect && (redir_cnt_q != '1)) begin
            redir_cnt_q <= redir_cnt_q + 1'b1;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clock) begin
        if (wb_req && !wb_we) begin
            case (wb_adr)
                npc_pkg::REG_CTRL_ADR:  wb_dat_r <= npc_pkg::wb_dat_t'(ctrl_q);
                npc_pkg::REG_REDIR_ADR: wb_dat_r <= redir_cnt_q;
                default:                wb_dat_r <= '0;
            endcase
        end
    end

    a_ack_single: assert property (
        @(posedge clock) disable iff (!rst_n) wb_ack |=> !wb_ack
    );

endmodule

`default_nettype wire

/* source/npc_unit_top.sv */
/*
 * Next-PC unit top level
 * Prediction control path beside the Wishbone config block
 */
`timescale 1ns/1ps
`default_nettype none

module npc_unit_top (
    input  logic                clock,
    input  logic                rst_n,
    // Fetch side
    input  npc_pkg::pc_t        pc_in,
    input  npc_pkg::pc_t        pc_plus_4,
    input  logic                is_branch,
    input  logic                is_jump,
    input  logic                is_return,
    input  logic                squash,
    output npc_pkg::pc_t        npc_out,
    output logic                branch_predict,
    output npc_pkg::dirp_idx_t  dirp_tag,
    // Resolve ports from execute
    input  logic                ex_valid_0,
    input  logic                ex_is_branch_0,
    input  logic                ex_taken_0,
    input  npc_pkg::pc_t        ex_pc_0,
    input  npc_pkg::pc_t        ex_target_0,
    input  npc_pkg::dirp_idx_t  ex_idx_0,
    input  logic                ex_valid_1,
    input  logic                ex_is_branch_1,
    input  logic                ex_taken_1,
    input  npc_pkg::pc_t        ex_pc_1,
    input  npc_pkg::pc_t        ex_target_1,
    input  npc_pkg::dirp_idx_t  ex_idx_1,
    // Wishbone slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  npc_pkg::wb_adr_t    wb_adr,
    input  npc_pkg::wb_dat_t    wb_dat_w,
    output npc_pkg::wb_dat_t    wb_dat_r,
    output logic                wb_ack
);

    // Enables into the control path
    logic dirp_en;
    logic btb_en;
    logic ras_en;
    // Redirect pulse back to the counter
    logic redirect;

    npc_control u_npc_control (.*);

    predictor_config u_predictor_config (.*);

endmodule

`default_nettype wire

/* sim/npc_tb.sv */
/*
 * Testbench for the next-PC unit
 * Replays the stimulus file one step per line, drives on the
 * falling edge and checks fetch outputs and config reads
 */
`timescale 1ns/1ps
`default_nettype none

module npc_tb;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_STEPS  = 128;
    localparam int NUM_ARGS   = 7;
    localparam int NUM_TESTS  = 6;
    // Extra cycles for Wishbone acks
    localparam int ACK_ALLOW  = 16;

    // Operation words as read by %s
    localparam logic [63:0] OP_COMMENT = 64'("#");
    localparam logic [63:0] OP_FETCH   = 64'("FETCH");
    localparam logic [63:0] OP_TRAIN   = 64'("TRAIN");
    localparam logic [63:0] OP_WBWR    = 64'("WBWR");
    localparam logic [63:0] OP_WBRD    = 64'("WBRD");
    localparam logic [63:0] OP_SQUASH  = 64'("SQUASH");

    logic               clock;
    logic               rst_n;
    npc_pkg::pc_t       pc_in;
    npc_pkg::pc_t       pc_plus_4;
    logic               is_branch;
    logic               is_jump;
    logic               is_return;
    logic               squash;
    npc_pkg::pc_t       npc_out;
    logic               branch_predict;
    npc_pkg::dirp_idx_t dirp_tag;
    logic               ex_valid_0;
    logic               ex_is_branch_0;
    logic               ex_taken_0;
    npc_pkg::pc_t       ex_pc_0;
    npc_pkg::pc_t       ex_target_0;
    npc_pkg::dirp_idx_t ex_idx_0;
    logic               ex_valid_1;
    logic               ex_is_branch_1;
    logic               ex_taken_1;
    npc_pkg::pc_t       ex_pc_1;
    npc_pkg::pc_t       ex_target_1;
    npc_pkg::dirp_idx_t ex_idx_1;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    npc_pkg::wb_adr_t   wb_adr;
    npc_pkg::wb_dat_t   wb_dat_w;
    npc_pkg::wb_dat_t   wb_dat_r;
    logic               wb_ack;

    // Loaded stimulus
    logic [63:0] op_mem  [MAX_STEPS];
    logic [31:0] arg_mem [MAX_STEPS][NUM_ARGS];
    int          num_steps;
    string       test_name [NUM_TESTS+1];

    int pass_count;
    int fail_count;
    int cycle_count;
    int cycle_limit;

    npc_unit_top u_npc_unit_top (.*);

    //////////////////////////////////////////////////
    // Clock and run limit
    //////////////////////////////////////////////////
    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles before the stimulus ended", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Compare and count
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // All DUT inputs back to idle
    task automatic idle_inputs();
        pc_in          = '0;
        pc_plus_4      = '0;
        is_branch      = 1'b0;
        is_jump        = 1'b0;
        is_return      = 1'b0;
        squash         = 1'b0;
        ex_valid_0     = 1'b0;
        ex_is_branch_0 = 1'b0;
        ex_taken_0     = 1'b0;
        ex_pc_0        = '0;
        ex_target_0    = '0;
        ex_idx_0       = '0;
        ex_valid_1     = 1'b0;
        ex_is_branch_1 = 1'b0;
        ex_taken_1     = 1'b0;
        ex_pc_1        = '0;
        ex_target_1    = '0;
        ex_idx_1       = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////
    task automatic load_stimulus(output logic ok);
        int               fd;
        int               r;
        logic             done;
        logic             bad;
        logic [63:0]      op_word;
        logic [8*128-1:0] rest;
        logic [31:0]      a [NUM_ARGS];
        ok        = 1'b0;
        bad       = 1'b0;
        num_steps = 0;
        fd = $fopen("sim/npc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/npc_stimulus.txt for reading");
        end else begin
            done = 1'b0;
            while (!done) begin
                r = $fscanf(fd, "%s", op_word);
                if (r != 1) begin
                    done = 1'b1;
                end else if (op_word == OP_COMMENT) begin
                    // Skip the rest of a comment line
                    r = $fgets(rest, fd);
                end else if (num_steps == MAX_STEPS) begin
                    $display("Stimulus file holds more than %0d steps", MAX_STEPS);
                    bad  = 1'b1;
                    done = 1'b1;
                end else begin
                    r = $fscanf(fd, "%h %h %h %h %h %h %h",
                                a[0], a[1], a[2], a[3], a[4], a[5], a[6]);
                    if (r != NUM_ARGS) begin
                        $display("Stimulus step %0d is missing fields", num_steps);
                        bad  = 1'b1;
                        done = 1'b1;
                    end else begin
                        op_mem[num_steps] = op_word;
                        for (int k = 0; k < NUM_ARGS; k++) begin
                            arg_mem[num_steps][k] = a[k];
                        end
                        num_steps++;
                    end
                end
            end
            $fclose(fd);
            ok = (num_steps > 0) && !bad;
        end
    endtask

    // One bus access with the ack awaited at falling edges
    task automatic wb_transfer(input logic we, input logic [31:0] adr,
                               input logic [31:0] dat, input logic [31:0] exp);
        int waits;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[npc_pkg::WB_ADR_LEN-1:0];
        wb_dat_w = we ? dat : '0;
        waits    = 0;
        do begin
            @(negedge clock);
            waits++;
        end while (wb_ack !== 1'b1);
        // Ack seen so the bus is released
        check_val("wb_ack_cycles", 32'(waits), 32'd1);
        if (!we) begin
            check_val("wb_dat_r", wb_dat_r, exp);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Execute one loaded line in one cycle for fetch side steps
    task automatic run_step(input int idx);
        logic [63:0] op;
        logic [31:0] a [NUM_ARGS];
        op = op_mem[idx];
        for (int k = 0; k < NUM_ARGS; k++) begin
            a[k] = arg_mem[idx][k];
        end
        @(negedge clock);
        idle_inputs();
        if (op == OP_FETCH) begin
            // Flags are return, jump, branch from the top
            pc_in     = a[1];
            pc_plus_4 = a[1] + 32'd4;
            is_branch = a[2][0];
            is_jump   = a[2][1];
            is_return = a[2][2];
            #(CLK_PERIOD/2 - 10);
            check_val("npc_out", npc_out, a[3]);
            check_val("branch_predict", 32'(branch_predict), a[4]);
            check_val("dirp_tag", 32'(dirp_tag), a[5]);
        end else if (op == OP_TRAIN) begin
            ex_valid_0     = a[1][0];
            ex_is_branch_0 = a[1][0];
            ex_taken_0     = a[2][0];
            ex_pc_0        = a[3];
            ex_target_0    = a[4];
            ex_idx_0       = a[3][7:2];
            ex_valid_1     = a[1][1];
            ex_is_branch_1 = a[1][1];
            ex_taken_1     = a[2][1];
            ex_pc_1        = a[5];
            ex_target_1    = a[6];
            ex_idx_1       = a[5][7:2];
        end else if (op == OP_WBWR) begin
            wb_transfer(1'b1, a[1], a[2], 32'd0);
        end else if (op == OP_WBRD) begin
            wb_transfer(1'b0, a[1], 32'd0, a[2]);
        end else if (op == OP_SQUASH) begin
            squash = 1'b1;
        end else begin
            $display("Stimulus step %0d has an unknown operation", idx);
            fail_count++;
        end
    endtask

    task automatic report_test(input int t, input int errs);
        string name;
        name = (t >= 1 && t <= NUM_TESTS) ? test_name[t] : test_name[0];
        if (errs == 0) begin
            $display("Test %0d %s: passed", t, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", t, name, errs);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        logic ok;
        int   cur_test;
        int   err_mark;
        pass_count   = 0;
        fail_count   = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        rst_n        = 1'b0;
        idle_inputs();
        test_name[0] = "unnamed";
        test_name[1] = "reset state";
        test_name[2] = "direction training";
        test_name[3] = "return stack";
        test_name[4] = "predictor enables";
        test_name[5] = "redirect counter";
        test_name[6] = "dual port training";
        load_stimulus(ok);
        if (!ok) begin
            $display("No usable stimulus, nothing was run");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            cycle_limit = 4 * num_steps + ACK_ALLOW;
            repeat (3) @(posedge clock);
            @(negedge clock);
            rst_n    = 1'b1;
            cur_test = arg_mem[0][0];
            err_mark = fail_count;
            for (int i = 0; i < num_steps; i++) begin
                if (arg_mem[i][0] != cur_test) begin
                    report_test(cur_test, fail_count - err_mark);
                    cur_test = arg_mem[i][0];
                    err_mark = fail_count;
                end
                run_step(i);
            end
            report_test(cur_test, fail_count - err_mark);
            $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/npc_stimulus.txt */
# op test f1..f6 in hex, unused fields 0
# FETCH: pc flags(bit2 ret, bit1 call, bit0 branch) npc predict tag | TRAIN: valid taken pc0 tgt0 pc1 tgt1
# WBWR: adr data | WBRD: adr expected_data | SQUASH: no fields
FETCH 1 00001000 1 00001004 0 00 0
FETCH 1 00001044 1 00001048 0 11 0
FETCH 1 000010fc 1 00001100 0 3f 0
FETCH 1 00001008 0 0000100c 0 02 0
TRAIN 2 1 1 00001010 00002000 00000000 00000000
FETCH 2 00001010 1 00002000 1 04 0
TRAIN 2 2 2 00000000 00000000 00001010 00002000
FETCH 2 00001010 1 00002000 1 04 0
TRAIN 2 1 0 00001010 00002000 00000000 00000000
FETCH 2 00001010 1 00002000 1 04 0
TRAIN 2 1 0 00001010 00002000 00000000 00000000
FETCH 2 00001010 1 00001014 0 04 0
TRAIN 2 1 0 00001010 00002000 00000000 00000000
FETCH 2 00001010 1 00001014 0 04 0
FETCH 2 00001010 0 00001014 0 04 0
FETCH 3 00005000 2 00005004 0 00 0
FETCH 3 00005010 2 00005014 0 04 0
FETCH 3 00005020 2 00005024 0 08 0
FETCH 3 00005030 2 00005034 0 0c 0
FETCH 3 00005040 2 00005044 0 10 0
FETCH 3 00005050 2 00005054 0 14 0
FETCH 3 00005060 2 00005064 0 18 0
FETCH 3 00005070 2 00005074 0 1c 0
FETCH 3 00005080 2 00005084 0 20 0
FETCH 3 00006000 4 00005084 0 00 0
FETCH 3 00006010 4 00005074 0 04 0
FETCH 3 00006020 4 00005064 0 08 0
FETCH 3 00006030 4 00005054 0 0c 0
FETCH 3 00006040 4 00005044 0 10 0
FETCH 3 00006050 4 00005034 0 14 0
FETCH 3 00006060 4 00005024 0 18 0
FETCH 3 00006070 4 00005014 0 1c 0
FETCH 3 00006080 4 00006084 0 20 0
FETCH 3 00007000 2 00007004 0 00 0
FETCH 3 00007010 2 00007014 0 04 0
SQUASH 3 0 0 0 0 0 0
FETCH 3 00007100 4 00007104 0 00 0
TRAIN 4 1 1 00001010 00002000 00000000 00000000
TRAIN 4 1 1 00001010 00002000 00000000 00000000
FETCH 4 00001010 1 00002000 1 04 0
WBWR 4 0 00000005 0 0 0 0
FETCH 4 00001010 1 00001014 0 04 0
WBRD 4 0 00000005 0 0 0 0
FETCH 4 00007200 2 00007204 0 00 0
WBWR 4 0 00000003 0 0 0 0
FETCH 4 00007300 4 00007304 0 00 0
WBWR 4 0 00000007 0 0 0 0
FETCH 4 00007310 4 00007204 0 04 0
FETCH 4 00001010 1 00002000 1 04 0
WBRD 5 4 0000000e 0 0 0 0
WBWR 5 4 00000000 0 0 0 0
WBRD 5 4 00000000 0 0 0 0
FETCH 5 00001010 1 00002000 1 04 0
FETCH 5 00001010 1 00002000 1 04 0
WBRD 5 4 00000002 0 0 0 0
WBWR 5 8 ffffffff 0 0 0 0
WBRD 5 8 00000000 0 0 0 0
WBRD 5 0 00000007 0 0 0 0
TRAIN 6 3 3 00008020 00009000 00008020 00009100
FETCH 6 00008020 1 00009100 1 08 0
TRAIN 6 3 3 00008040 00009200 00008080 00009300
FETCH 6 00008080 1 00009300 1 20 0
FETCH 6 00008040 1 00008044 0 10 0

/* compile.f */
source/npc_pkg.sv
source/dirp_bimodal.sv
source/btb.sv
source/ras.sv
source/npc_control.sv
source/predictor_config.sv
source/npc_unit_top.sv
sim/npc_tb.sv

/* Makefile */
# Verilator build and run for the next-PC unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= npc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
